// File: bench/tile_mem_fabric_sva.sv
module tile_mem_fabric_sva import tile_mem_pkg::*; #(
    parameter int NUM_CORES = 4
) (
    input logic                 sys_clk,
    input logic                 sys_rst_n,
    input logic [NUM_CORES-1:0] core_req,
    input logic [NUM_CORES-1:0] core_ack,
    input logic                 mem_req,
    input mem_cmd_t             mem_cmd
);

    timeunit 1ns;
    timeprecision 1ps;

    // Only the granted core may see an ack
    ack_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        $onehot0(core_ack))
        else $error("core_ack has more than one bit set");

    // Granted command held for the whole memory request
    mem_cmd_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        mem_req |=> (!mem_req || $stable(mem_cmd)))
        else $error("mem_cmd changed while mem_req was high");

    // Four-phase rules per core
    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        // Ack held until its req drops
        ack_hold: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            core_ack[c] && core_req[c] |=> core_ack[c])
            else $error("core_ack[%0d] fell while its req was high", c);

        // Idle core stays idle until it requests
        ack_needs_req: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
            !core_req[c] && !core_ack[c] |=> !core_ack[c])
            else $error("core_ack[%0d] rose without a request", c);
    end

endmodule

bind tile_mem_fabric tile_mem_fabric_sva #(
    .NUM_CORES (NUM_CORES)
) sva_i (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .core_req  (core_req),
    .core_ack  (core_ack),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd)
);

// File: bench/tile_mem_fabric_tb.sv
module tile_mem_fabric_tb import tile_mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_CORES      = 4;
    localparam int RAM_DEPTH      = 256;
    localparam int NUM_ENTRIES    = 10;
    localparam int TIMEOUT_CYCLES = 20 * NUM_ENTRIES * NUM_CORES + 100;

    // One contest between the cores in mask
    // Packed lists hold core 3 or grant 3 in the top field
    typedef struct packed {
        logic [3:0]      mask;
        logic [3:0]      wen;
        addr_t [3:0]     addr;
        logic [3:0][2:0] slot;
        logic            rd_zero;
        logic [2:0]      rd_slot;
        logic [3:0][1:0] order;
    } stim_t;

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic [NUM_CORES-1:0] core_req;
    mem_cmd_t             core_cmd [NUM_CORES];
    logic [NUM_CORES-1:0] core_ack;
    word_t                core_rdata;

    stim_t stim_table [NUM_ENTRIES];
    // Random data words picked by slot number
    word_t pool [8];
    // Expected memory contents and read word
    word_t model_mem [RAM_DEPTH];
    word_t exp_rdata;
    int    last_winner;
    int    seed = 99108;
    int    cycle_count = 0;

    tile_mem_fabric #(
        .NUM_CORES (NUM_CORES),
        .RAM_DEPTH (RAM_DEPTH)
    ) dut_i (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .core_req   (core_req),
        .core_cmd   (core_cmd),
        .core_ack   (core_ack),
        .core_rdata (core_rdata)
    );

    // ============================================================
    // Clock and run limit
    // ============================================================

    initial sys_clk = 1'b0;
    always #50 sys_clk = ~sys_clk;

    always @(posedge sys_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: table not finished after %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    // ============================================================
    // Checking helpers
    // ============================================================

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got 0x%h expected 0x%h",
                     $time, name, got, exp);
            fail_run();
        end
    endtask

    // Next winner is the first pending core after the last one with wraparound
    function automatic int rr_pick(input logic [NUM_CORES-1:0] pending, input int last);
        int c;
        int pick;
        pick = -1;
        for (int off = 1; off <= NUM_CORES; off++) begin
            c = (last + off) % NUM_CORES;
            if (pick < 0 && pending[c]) begin
                pick = c;
            end
        end
        return pick;
    endfunction

    // ============================================================
    // Stimulus table
    // ============================================================

    // Slot numbers in octal with one digit per core
    // Order gives two bits per grant
    task automatic load_table();
        // All four after reset with the scan starting at core 1
        stim_table[0] = '{mask: 4'b1111, wen: 4'b1111, addr: 64'h0023_0022_0021_0020,
                          slot: 12'o3210, rd_zero: 1'b0, rd_slot: 3'd0, order: 8'b00_11_10_01};
        stim_table[1] = '{mask: 4'b0010, wen: 4'b0010, addr: 64'h0000_0000_0040_0000,
                          slot: 12'o0040, rd_zero: 1'b0, rd_slot: 3'd0, order: 8'b00_00_00_01};
        // Same core reads its own word back
        stim_table[2] = '{mask: 4'b0010, wen: 4'b0000, addr: 64'h0000_0000_0040_0000,
                          slot: 12'o0000, rd_zero: 1'b0, rd_slot: 3'd4, order: 8'b00_00_00_01};
        // Every other core sees it
        stim_table[3] = '{mask: 4'b1101, wen: 4'b0000, addr: 64'h0040_0040_0000_0040,
                          slot: 12'o0000, rd_zero: 1'b0, rd_slot: 3'd4, order: 8'b00_00_11_10};
        // Two writers to one word with core 3 granted last
        stim_table[4] = '{mask: 4'b1010, wen: 4'b1010, addr: 64'h0050_0000_0050_0000,
                          slot: 12'o6050, rd_zero: 1'b0, rd_slot: 3'd0, order: 8'b00_00_11_01};
        stim_table[5] = '{mask: 4'b0100, wen: 4'b0000, addr: 64'h0000_0050_0000_0000,
                          slot: 12'o0000, rd_zero: 1'b0, rd_slot: 3'd6, order: 8'b00_00_00_10};
        // Alias pair 0x0007 and 0x0107
        stim_table[6] = '{mask: 4'b0001, wen: 4'b0001, addr: 64'h0000_0000_0000_0007,
                          slot: 12'o0007, rd_zero: 1'b0, rd_slot: 3'd0, order: 8'b00_00_00_00};
        stim_table[7] = '{mask: 4'b1000, wen: 4'b0000, addr: 64'h0107_0000_0000_0000,
                          slot: 12'o0000, rd_zero: 1'b0, rd_slot: 3'd7, order: 8'b00_00_00_11};
        // Write then three reads in one contest
        stim_table[8] = '{mask: 4'b1111, wen: 4'b0001, addr: 64'h0021_0021_0021_0021,
                          slot: 12'o0005, rd_zero: 1'b0, rd_slot: 3'd5, order: 8'b11_10_01_00};
        // Never written word reads as zero
        stim_table[9] = '{mask: 4'b0010, wen: 4'b0000, addr: 64'h0000_0000_00ff_0000,
                          slot: 12'o0000, rd_zero: 1'b1, rd_slot: 3'd0, order: 8'b00_00_00_01};
    endtask

    // ============================================================
    // Transaction driver
    // ============================================================

    // Called 5 ns after an edge with the fabric idle
    task automatic run_entry(input int e);
        stim_t                ent;
        logic [NUM_CORES-1:0] pending;
        int                   served;
        int                   winner;
        int                   cycles;
        int                   idx;
        word_t                table_word;

        ent     = stim_table[e];
        pending = ent.mask;
        served  = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            if (ent.mask[c]) begin
                core_cmd[c] = '{addr: ent.addr[c], wen: ent.wen[c], wdata: pool[ent.slot[c]]};
                core_req[c] = 1'b1;
            end
        end
        while (pending != '0) begin
            // Wait for the next grant
            // The run limit catches a stall
            cycles = 0;
            do begin
                @(posedge sys_clk);
                #5;
                cycles++;
            end while (core_ack == '0);
            check_val("core_ack ones", 64'($countones(core_ack)), 64'd1);
            winner = 0;
            for (int c = 0; c < NUM_CORES; c++) begin
                if (core_ack[c]) begin
                    winner = c;
                end
            end
            // Idle fabric answers two edges after the request
            if (served == 0) begin
                check_val("first ack latency", 64'(cycles), 64'd2);
            end
            check_val("winner", 64'(winner), 64'(ent.order[served]));
            check_val("winner", 64'(winner), 64'(rr_pick(pending, last_winner)));
            idx = int'(ent.addr[winner]) % RAM_DEPTH;
            if (ent.wen[winner]) begin
                // Write keeps the last read word on the bus
                check_val("core_rdata", core_rdata, exp_rdata);
                model_mem[idx] = pool[ent.slot[winner]];
            end else begin
                table_word = ent.rd_zero ? '0 : pool[ent.rd_slot];
                check_val("core_rdata", core_rdata, model_mem[idx]);
                check_val("core_rdata", core_rdata, table_word);
                exp_rdata = model_mem[idx];
            end
            // Request held across one more edge while ack stays up
            @(posedge sys_clk);
            #5;
            check_val("core_ack hold", 64'(core_ack[winner]), 64'd1);
            // Release the request and expect ack to drop one edge later
            core_req[winner] = 1'b0;
            pending[winner]  = 1'b0;
            last_winner      = winner;
            served++;
            @(posedge sys_clk);
            #5;
            check_val("core_ack release", 64'(core_ack[winner]), 64'd0);
        end
        // Arbiter back in ARB_IDLE
        @(posedge sys_clk);
        #5;
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        sys_rst_n   = 1'b0;
        core_req    = '0;
        exp_rdata   = '0;
        last_winner = 0;
        for (int c = 0; c < NUM_CORES; c++) begin
            core_cmd[c] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            pool[i] = {$random(seed), $random(seed)};
        end
        for (int i = 0; i < RAM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        load_table();

        repeat (10) @(posedge sys_clk);
        #5;
        sys_rst_n = 1'b1;
        @(posedge sys_clk);
        #5;
        check_val("core_ack", 64'(core_ack), 64'd0);
        check_val("core_rdata", core_rdata, 64'd0);

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the tile memory fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    -f sim.f --top-module tile_mem_fabric_tb -o tile_mem_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tile_mem_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

// File: sim.f
source/tile_mem_pkg.sv
source/tile_port_arbiter.sv
source/shared_tile_ram.sv
source/tile_mem_fabric.sv
bench/tile_mem_fabric_sva.sv
bench/tile_mem_fabric_tb.sv

// File: source/shared_tile_ram.sv
module shared_tile_ram import tile_mem_pkg::*; #(
    parameter int RAM_DEPTH = 256
) (
    input  logic     sys_clk,
    input  logic     sys_rst_n,

    // Four-phase slave port
    input  logic     mem_req,
    input  mem_cmd_t mem_cmd,
    output logic     mem_ack,
    output word_t    mem_rdata
);

    // Word index width, depth is a power of two
    localparam int IDX_W = $clog2(RAM_DEPTH);

    typedef logic [IDX_W-1:0] ram_idx_t;

    // ============================================================
    // Storage and handshake state
    // ============================================================

    word_t      mem_array [RAM_DEPTH];
    ram_state_e ram_state;

    // Address folded onto the array by dropping the upper bits
    ram_idx_t   word_idx;

    // One access per handshake, taken on the edge that leaves RAM_IDLE
    logic       do_access;

    assign word_idx  = mem_cmd.addr[IDX_W-1:0];
    assign do_access = (ram_state == RAM_IDLE) && mem_req;
    assign mem_ack   = (ram_state == RAM_ACK);

    // ============================================================
    // Handshake FSM
    // ============================================================

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            ram_state <= RAM_IDLE;
        end else begin
            case (ram_state)
                RAM_IDLE: begin
                    if (mem_req) begin
                        ram_state <= RAM_ACK;
                    end
                end
                RAM_ACK: begin
                    // Hold ack until the requester releases req
                    if (!mem_req) begin
                        ram_state <= RAM_IDLE;
                    end
                end
                default: begin
                    ram_state <= RAM_IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // Array access
    // ============================================================

    // Contents and read word start from zero
    // A write leaves mem_rdata untouched
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            for (int i = 0; i < RAM_DEPTH; i++) begin
                mem_array[i] <= '0;
            end
            mem_rdata <= '0;
        end else if (do_access) begin
            if (mem_cmd.wen) begin
                mem_array[word_idx] <= mem_cmd.wdata;
            end else begin
                mem_rdata <= mem_array[word_idx];
            end
        end
    end

endmodule

// File: source/tile_mem_fabric.sv
module tile_mem_fabric import tile_mem_pkg::*; #(
    // Requesters sharing the port, 2 to 8
    parameter int NUM_CORES = 4,
    // Words in the shared memory, power of two
    parameter int RAM_DEPTH = 256
) (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,

    // Per-core request side
    input  logic [NUM_CORES-1:0] core_req,
    input  mem_cmd_t             core_cmd [NUM_CORES],
    output logic [NUM_CORES-1:0] core_ack,

    // Read word broadcast to every core
    output word_t                core_rdata
);

    // ============================================================
    // Arbiter to memory link
    // ============================================================

    logic     mem_req;
    mem_cmd_t mem_cmd;
    logic     mem_ack;

    // Round-robin arbiter, one core on the port at a time
    tile_port_arbiter #(
        .NUM_CORES (NUM_CORES)
    ) arbiter_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .core_req  (core_req),
        .core_cmd  (core_cmd),
        .core_ack  (core_ack),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack)
    );

    // ============================================================
    // Shared word memory
    // ============================================================

    // Read data goes straight out to all cores
    // Only the granted core gets the ack that qualifies it
    shared_tile_ram #(
        .RAM_DEPTH (RAM_DEPTH)
    ) ram_i (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .mem_req   (mem_req),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (core_rdata)
    );

endmodule

// File: source/tile_mem_pkg.sv
package tile_mem_pkg;

    // ============================================================
    // Data path widths
    // ============================================================

    // One shared memory word, as seen by every core
    typedef logic [63:0] word_t;

    // Word address issued by a core
    // The memory folds it modulo its own depth
    typedef logic [15:0] addr_t;

    // ============================================================
    // Request command
    // ============================================================

    // Held stable by the requester for as long as its req is high
    // 16 + 1 + 64 = 81 bits
    typedef struct packed {
        addr_t addr;
        logic  wen;
        word_t wdata;
    } mem_cmd_t;

    // ============================================================
    // FSM encodings
    // ============================================================

    // Arbiter is either scanning for a winner or owning the port
    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_e;

    // Memory slave waits for req, then holds ack until req drops
    typedef enum logic {
        RAM_IDLE,
        RAM_ACK
    } ram_state_e;

endpackage

// File: source/tile_port_arbiter.sv
module tile_port_arbiter import tile_mem_pkg::*; #(
    parameter int NUM_CORES = 4
) (
    input  logic                 sys_clk,
    input  logic                 sys_rst_n,

    // Core side, one req/ack pair per core
    input  logic [NUM_CORES-1:0] core_req,
    input  mem_cmd_t             core_cmd [NUM_CORES],
    output logic [NUM_CORES-1:0] core_ack,

    // Shared memory port
    output logic                 mem_req,
    output mem_cmd_t             mem_cmd,
    input  logic                 mem_ack
);

    // Grant index width follows the core count
    localparam int GRANT_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    typedef logic [GRANT_W-1:0] grant_t;

    // ============================================================
    // Arbiter state
    // ============================================================

    arb_state_e arb_state;

    // Core that currently owns the memory port
    grant_t     grant;

    // Winner of the previous transaction, start point of the scan
    grant_t     last_grant;

    // Result of the combinational scan
    grant_t     next_grant;
    logic       next_any;

    logic       arb_busy;

    assign arb_busy = (arb_state == ARB_BUSY);

    // ============================================================
    // Round-robin scan
    // ============================================================

    // Walk from the farthest core back towards last_grant + 1
    // The nearest requester after the last winner is written last and wins
    // The last winner itself is the farthest candidate
    always_comb begin
        int cand;

        next_any   = 1'b0;
        next_grant = last_grant;
        for (int off = NUM_CORES; off >= 1; off--) begin
            cand = int'(last_grant) + off;
            // Wrap without a divider, sum is below 2*NUM_CORES
            if (cand >= NUM_CORES) begin
                cand = cand - NUM_CORES;
            end
            if (core_req[cand]) begin
                next_any   = 1'b1;
                next_grant = grant_t'(cand);
            end
        end
    end

    // ============================================================
    // Grant FSM
    // ============================================================

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            arb_state  <= ARB_IDLE;
            grant      <= '0;
            // Scan after reset starts at core 1
            last_grant <= '0;
        end else begin
            case (arb_state)
                ARB_IDLE: begin
                    // Latch the winner, mem_req follows on the next cycle
                    if (next_any) begin
                        grant     <= next_grant;
                        arb_state <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    // Leave only once the four-phase cycle has fully closed
                    if (!core_req[grant] && !mem_ack) begin
                        last_grant <= grant;
                        arb_state  <= ARB_IDLE;
                    end
                end
                default: begin
                    arb_state <= ARB_IDLE;
                end
            endcase
        end
    end

    // ============================================================
    // Command mux and acknowledge routing
    // ============================================================

    // Winner's req drives the memory port straight through while busy
    assign mem_req = arb_busy && core_req[grant];

    // Command of the granted core, stable because its req is held
    assign mem_cmd = core_cmd[grant];

    // Only the winner ever sees the ack
    always_comb begin
        core_ack = '0;
        if (arb_busy) begin
            core_ack[grant] = mem_ack;
        end
    end

endmodule
